//--- hdl/fpm_config.svh
`ifndef FPM_CONFIG_SVH
`define FPM_CONFIG_SVH

// single-precision field widths
`define FPM_EXP_W 8
`define FPM_FRAC_W 23

// excess-127 exponent encoding
`define FPM_EXP_BIAS 127

// bits per lookahead group in the product adder
`define FPM_CLA_GROUP 4

// cycles from inValid to outValid, one per register stage
`define FPM_PIPE_DEPTH 3

`endif

//--- hdl/fpm_pkg.sv
`include "fpm_config.svh"

package fpm_pkg;

  // packed word: sign, biased exponent, stored fraction
  typedef logic [`FPM_EXP_W+`FPM_FRAC_W:0] floatT;

  // biased exponent, wraps modulo 256
  typedef logic [`FPM_EXP_W-1:0] expT;

  // stored fraction without the hidden one
  typedef logic [`FPM_FRAC_W-1:0] fracT;

  // significand with the hidden one restored
  typedef logic [`FPM_FRAC_W:0] mantT;

  // full significand product, always below 4.0
  typedef logic [2*`FPM_FRAC_W+1:0] prodT;

endpackage

//--- hdl/wallaceTree.sv
`timescale 1ns/1ps

module wallaceTree
  import fpm_pkg::*;
(
  input  mantT multiplicand,
  input  mantT multiplier,
  output prodT sumRow,
  output prodT carryRow
);

  localparam int Width = $bits(prodT);
  localparam int Rows = $bits(mantT);

  // rows left after a number of 3:2 layers
  function automatic int rowsAfter(int layer);
    int n;
    n = Rows;
    for (int i = 0; i < layer; i++)
    begin
      n = (n / 3) * 2 + n % 3;
    end
    return n;
  endfunction

  // layers until only a sum row and a carry row remain
  function automatic int layersNeeded();
    int n;
    int count;
    n = Rows;
    count = 0;
    while (n > 2)
    begin
      n = (n / 3) * 2 + n % 3;
      count++;
    end
    return count;
  endfunction

  localparam int Layers = layersNeeded();

  // rows[l] holds the operands entering layer l
  wire prodT rows [0:Layers][0:Rows-1];

  // one shifted copy of the multiplicand per multiplier bit
  for (genvar i = 0; i < Rows; i++)
  begin : gPartial
    assign rows[0][i] = multiplier[i] ? (prodT'(multiplicand) << i) : '0;
  end

  // 24 -> 16 -> 11 -> 8 -> 6 -> 4 -> 3 -> 2
  for (genvar l = 0; l < Layers; l++)
  begin : gLayer
    localparam int NumIn = rowsAfter(l);
    localparam int NumGroups = NumIn / 3;
    localparam int NumLeft = NumIn % 3;

    // rows taken three at a time, sum and carry kept side by side
    for (genvar g = 0; g < NumGroups; g++)
    begin : gCsa
      localparam int Base = 3 * g;
      wire prodT sumBits;
      wire [Width-2:0] majBits;

      for (genvar k = 0; k < Width; k++)
      begin : gFa
        wire xBit = rows[l][Base][k];
        wire yBit = rows[l][Base+1][k];
        wire zBit = rows[l][Base+2][k];

        assign sumBits[k] = xBit ^ yBit ^ zBit;

        // carry out of the top column is beyond the product width
        if (k < Width - 1)
        begin : gMaj
          assign majBits[k] = (xBit & yBit) | (yBit & zBit) | (zBit & xBit);
        end
      end

      assign rows[l+1][2*g] = sumBits;
      assign rows[l+1][2*g+1] = {majBits, 1'b0};
    end

    // rows outside a full group wait for the next layer
    for (genvar r = 0; r < NumLeft; r++)
    begin : gPass
      assign rows[l+1][2*NumGroups+r] = rows[l][3*NumGroups+r];
    end

    // unused slots of the row array are tied off
    for (genvar u = 2 * NumGroups + NumLeft; u < Rows; u++)
    begin : gIdle
      assign rows[l+1][u] = '0;
    end
  end

  assign sumRow = rows[Layers][0];
  assign carryRow = rows[Layers][1];

endmodule

//--- hdl/claAdder.sv
`timescale 1ns/1ps
`include "fpm_config.svh"

module claAdder
  import fpm_pkg::*;
#(
  parameter int groupWidth = `FPM_CLA_GROUP
)
(
  input  prodT opA,
  input  prodT opB,
  output prodT sum
);

  localparam int Width = $bits(prodT);
  localparam int Groups = Width / groupWidth;

  if (Width % groupWidth != 0)
  begin : gBadGroup
    $error("claAdder: groupWidth %0d does not divide %0d", groupWidth, Width);
  end

  prodT bitGen;
  prodT bitProp;
  prodT carry;
  logic [Groups-1:0] grpGen;
  logic [Groups-1:0] grpProp;
  logic [Groups-1:0] grpCarry;

  assign bitGen = opA & opB;
  assign bitProp = opA ^ opB;

  // group generate and propagate
  always_comb
  begin : groupTerms
    for (int j = 0; j < Groups; j++)
    begin
      grpGen[j] = 1'b0;
      grpProp[j] = 1'b1;
      for (int i = 0; i < groupWidth; i++)
      begin
        grpGen[j] = bitGen[j*groupWidth+i] | (bitProp[j*groupWidth+i] & grpGen[j]);
        grpProp[j] = grpProp[j] & bitProp[j*groupWidth+i];
      end
    end
  end

  // carry into each group, flat across all lower groups
  always_comb
  begin : lookahead
    logic chain;
    for (int j = 0; j < Groups; j++)
    begin
      grpCarry[j] = 1'b0;
      for (int k = 0; k < j; k++)
      begin
        chain = grpGen[k];
        for (int m = k + 1; m < j; m++)
        begin
          chain = chain & grpProp[m];
        end
        grpCarry[j] = grpCarry[j] | chain;
      end
    end
  end

  // ripple only inside a group
  always_comb
  begin : bitCarries
    for (int j = 0; j < Groups; j++)
    begin
      carry[j*groupWidth] = grpCarry[j];
      for (int i = 1; i < groupWidth; i++)
      begin
        carry[j*groupWidth+i] = bitGen[j*groupWidth+i-1]
                                | (bitProp[j*groupWidth+i-1] & carry[j*groupWidth+i-1]);
      end
    end
  end

  assign sum = bitProp ^ carry;

endmodule

//--- hdl/resultNormalize.sv
`timescale 1ns/1ps
`include "fpm_config.svh"

module resultNormalize
  import fpm_pkg::*;
(
  input  prodT product,
  input  expT  expIn,
  output fracT frac,
  output expT  expOut
);

  localparam int TopBit = $bits(prodT) - 1;

  // both significands are in [1,2), so the product is in [1,4)
  logic overTwo;

  assign overTwo = product[TopBit];

  always_comb
  begin
    if (overTwo)
    begin
      // leading one at bit 47, one right shift
      frac = product[TopBit-1 -: `FPM_FRAC_W];
      expOut = expIn + expT'(1);
    end
    else
    begin
      // leading one at bit 46, already normalized
      frac = product[TopBit-2 -: `FPM_FRAC_W];
      expOut = expIn;
    end
  end

endmodule

//--- hdl/fpMultiplier.sv
`timescale 1ns/1ps
`include "fpm_config.svh"

module fpMultiplier
  import fpm_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  inValid,
  input  floatT a,
  input  floatT b,
  output logic  outValid,
  output floatT result
);

  localparam int Depth = `FPM_PIPE_DEPTH;
  localparam int SignBit = $bits(floatT) - 1;

  logic signA;
  logic signB;
  expT  expA;
  expT  expB;
  fracT fracA;
  fracT fracB;
  expT  expSum;

  // stage 1
  logic s1Sign;
  expT  s1Exp;
  mantT s1MantA;
  mantT s1MantB;

  // stage 2
  logic s2Sign;
  expT  s2Exp;
  prodT s2Prod;

  prodT sumRow;
  prodT carryRow;
  prodT product;
  fracT normFrac;
  expT  normExp;

  logic [Depth-1:0] validPipe;

  // field unpacking
  assign signA = a[SignBit];
  assign signB = b[SignBit];
  assign expA = a[SignBit-1 -: `FPM_EXP_W];
  assign expB = b[SignBit-1 -: `FPM_EXP_W];
  assign fracA = a[`FPM_FRAC_W-1:0];
  assign fracB = b[`FPM_FRAC_W-1:0];

  // bias counted twice in the sum, removed once
  assign expSum = expA + expB - expT'(`FPM_EXP_BIAS);

  always_ff @(posedge clk)
  begin
    if (inValid)
    begin
      s1Sign <= signA ^ signB;
      s1Exp <= expSum;
      s1MantA <= {1'b1, fracA};
      s1MantB <= {1'b1, fracB};
    end
  end

  wallaceTree uWallace (
    .multiplicand (s1MantA),
    .multiplier   (s1MantB),
    .sumRow       (sumRow),
    .carryRow     (carryRow)
  );

  claAdder #(
    .groupWidth (`FPM_CLA_GROUP)
  ) uCla (
    .opA (sumRow),
    .opB (carryRow),
    .sum (product)
  );

  always_ff @(posedge clk)
  begin
    if (validPipe[0])
    begin
      s2Sign <= s1Sign;
      s2Exp <= s1Exp;
      s2Prod <= product;
    end
  end

  resultNormalize uNorm (
    .product (s2Prod),
    .expIn   (s2Exp),
    .frac    (normFrac),
    .expOut  (normExp)
  );

  // stage 3 drives the output directly
  always_ff @(posedge clk)
  begin
    if (validPipe[1])
    begin
      result <= {s2Sign, normExp, normFrac};
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      validPipe <= '0;
    end
    else
    begin
      validPipe <= {validPipe[Depth-2:0], inValid};
    end
  end

  assign outValid = validPipe[Depth-1];

endmodule

//--- verif/fpMultiplier_assertions.sv
`timescale 1ns/1ps
`include "fpm_config.svh"

module fpMultiplier_assertions
  import fpm_pkg::*;
(
  input logic  clk,
  input logic  rst,
  input logic  inValid,
  input floatT a,
  input floatT b,
  input logic  outValid,
  input floatT result
);

  localparam int Depth = `FPM_PIPE_DEPTH;
  localparam int SignBit = $bits(floatT) - 1;
  localparam int FracW = `FPM_FRAC_W;
  localparam int ExpW = `FPM_EXP_W;

  int failCount;
  logic [Depth-1:0] validDelay;
  floatT expectPipe [Depth];
  floatT expected;

  // sign xor, exact 24x24 product, at most one right shift
  function automatic floatT ruleResult(floatT x, floatT y);
    prodT full;
    expT e;
    fracT f;
    full = prodT'({1'b1, x[FracW-1:0]}) * prodT'({1'b1, y[FracW-1:0]});
    e = x[SignBit-1 -: ExpW] + y[SignBit-1 -: ExpW] - expT'(`FPM_EXP_BIAS);
    if (full[2*FracW+1])
    begin
      f = full[2*FracW -: FracW];
      e = e + expT'(1);
    end
    else
    begin
      f = full[2*FracW-1 -: FracW];
    end
    return {x[SignBit] ^ y[SignBit], e, f};
  endfunction

  initial failCount = 0;

  // expected value and strobe delayed by the pipeline depth
  always_ff @(posedge clk)
  begin
    expectPipe[0] <= ruleResult(a, b);
    for (int i = 1; i < Depth; i++)
    begin
      expectPipe[i] <= expectPipe[i-1];
    end
    if (rst)
      validDelay <= '0;
    else
      validDelay <= {validDelay[Depth-2:0], inValid};
  end

  assign expected = expectPipe[Depth-1];

  resetCheck: assert property (@(posedge clk) rst |=> !outValid)
    else
    begin
      $error("error outValid: expected 0, got %h", $sampled(outValid));
      failCount++;
    end

  validCheck: assert property (@(posedge clk) disable iff (rst)
    outValid == validDelay[Depth-1])
    else
    begin
      $error("error outValid: expected %h, got %h",
             $sampled(validDelay[Depth-1]), $sampled(outValid));
      failCount++;
    end

  signCheck: assert property (@(posedge clk) disable iff (rst)
    outValid |-> result[SignBit] == expected[SignBit])
    else
    begin
      $error("error result sign: expected %h, got %h",
             $sampled(expected[SignBit]), $sampled(result[SignBit]));
      failCount++;
    end

  expCheck: assert property (@(posedge clk) disable iff (rst)
    outValid |-> result[SignBit-1 -: ExpW] == expected[SignBit-1 -: ExpW])
    else
    begin
      $error("error result exponent: expected %h, got %h",
             $sampled(expected[SignBit-1 -: ExpW]), $sampled(result[SignBit-1 -: ExpW]));
      failCount++;
    end

  fracCheck: assert property (@(posedge clk) disable iff (rst)
    outValid |-> result[FracW-1:0] == expected[FracW-1:0])
    else
    begin
      $error("error result fraction: expected %h, got %h",
             $sampled(expected[FracW-1:0]), $sampled(result[FracW-1:0]));
      failCount++;
    end

endmodule

//--- verif/fpMultiplier_tb.sv
`timescale 1ns/1ps

module fpMultiplier_tb
  import fpm_pkg::*;
;

  localparam int Period = 100;
  localparam int ResetCycles = 16;
  localparam int RandomOps = 200;
  localparam int GapOps = 100;
  localparam int GapCycles = 300;
  localparam int Margin = 50;
  localparam int MinExp = 64;
  localparam int MaxExp = 190;

  logic clk;
  logic rst;
  logic inValid;
  floatT a;
  floatT b;
  logic outValid;
  floatT result;

  integer seed;
  int sentCount;
  int outCount;

  fpMultiplier u_dut (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .a        (a),
    .b        (b),
    .outValid (outValid),
    .result   (result)
  );

  bind fpMultiplier fpMultiplier_assertions uChk (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .a        (a),
    .b        (b),
    .outValid (outValid),
    .result   (result)
  );

  always #(Period / 2) clk = ~clk;

  // exponent kept in range so the result never wraps
  function automatic floatT randomOperand();
    logic sign;
    expT e;
    fracT f;
    sign = 1'($random(seed));
    e = expT'(MinExp + ($unsigned($random(seed)) % (MaxExp - MinExp + 1)));
    f = fracT'($random(seed));
    return {sign, e, f};
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic sendOp(input floatT x, input floatT y);
    @(posedge clk);
    #1;
    inValid = 1'b1;
    a = x;
    b = y;
    sentCount++;
  endtask

  // operands keep changing while inValid is low
  task automatic idleCycles(input int cycles);
    repeat (cycles)
    begin
      @(posedge clk);
      #1;
      inValid = 1'b0;
      a = randomOperand();
      b = randomOperand();
    end
  endtask

  always @(posedge clk)
  begin
    if (!rst && outValid)
      outCount++;
  end

  initial
  begin
    #((ResetCycles + RandomOps + GapCycles + Margin) * Period);
    failRun("timeout: the run did not finish in the expected time");
  end

  initial
  begin
    wait (u_dut.uChk.failCount != 0);
    failRun("a result check in the bound checker failed");
  end

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    inValid = 1'b0;
    a = '0;
    b = '0;
    seed = 50;
    sentCount = 0;
    outCount = 0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst = 1'b0;
    idleCycles(4);

    // directed sign combinations and both normalize cases
    sendOp(32'h3F800000, 32'h3FC00000);
    idleCycles(1);
    sendOp(32'h3FC00000, 32'h3FC00000);
    idleCycles(1);
    sendOp(32'hBFC00000, 32'h3FC00000);
    idleCycles(1);
    sendOp(32'h3FC00000, 32'hBFC00000);
    idleCycles(1);
    sendOp(32'hBFC00000, 32'hBFC00000);
    idleCycles(1);
    sendOp(32'h3FFFFFFF, 32'h3FFFFFFF);
    idleCycles(1);
    sendOp(32'hC2FFFFFF, 32'h3FFFFFFF);
    idleCycles(1);
    sendOp(32'h40490FDB, 32'h402DF854);
    idleCycles(1);
    sendOp(32'h20000000, 32'h5F000000);
    idleCycles(1);

    // back to back with three in flight
    repeat (RandomOps)
    begin
      sendOp(randomOperand(), randomOperand());
    end
    idleCycles(1);

    // random gaps of zero to two cycles
    repeat (GapOps)
    begin
      sendOp(randomOperand(), randomOperand());
      idleCycles($unsigned($random(seed)) % 3);
    end
    idleCycles(1);

    wait (outCount == sentCount);
    repeat (2) @(posedge clk);
    if (u_dut.uChk.failCount == 0)
    begin
      $display("Result: PASSED");
      $finish;
    end
    else
    begin
      failRun("checks failed during the run");
    end
  end

endmodule

//--- vlog.f
+incdir+hdl
hdl/fpm_pkg.sv
hdl/wallaceTree.sv
hdl/claAdder.sv
hdl/resultNormalize.sv
hdl/fpMultiplier.sv
verif/fpMultiplier_assertions.sv
verif/fpMultiplier_tb.sv

//--- Bender.yml
package:
  name: fp_multiplier

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fpm_pkg.sv
      - hdl/wallaceTree.sv
      - hdl/claAdder.sv
      - hdl/resultNormalize.sv
      - hdl/fpMultiplier.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/fpMultiplier_assertions.sv
      - verif/fpMultiplier_tb.sv
